// ==== hw/ctrlport_pkg.sv ====
// control-port widths and status codes, referenced by scoped name from rtl and testbench

package ctrlport_pkg;

  // --------------------------------------------------------------------------
  // bus widths
  // --------------------------------------------------------------------------

  // request address, byte offset into the register space
  localparam int addr_w = 20;

  // request and response data word
  localparam int data_w = 32;

  // execution timestamp, compared against radio time
  localparam int time_w = 64;

  // --------------------------------------------------------------------------
  // response status
  // --------------------------------------------------------------------------

  // status field width on the response side
  localparam int status_w = 2;

  typedef logic [status_w-1:0] status_t;

  // completed access
  localparam status_t sts_okay = 2'b00;

endpackage

// ==== hw/rfdc_regmap_pkg.sv ====
// register map of the rfdc reset block: offsets, field layout and the shared register word

package rfdc_regmap_pkg;

  // --------------------------------------------------------------------------
  // register offsets
  // --------------------------------------------------------------------------

  // nco reset control, start strobe and done status
  localparam logic [ctrlport_pkg::addr_w-1:0] nco_reset_reg_addr = 20'h00000;

  // adc and dac gearbox reset strobes
  localparam logic [ctrlport_pkg::addr_w-1:0] gearbox_reset_reg_addr = 20'h00004;

  // flops in the done-flag synchronizer
  localparam int sync_stages = 2;

  // --------------------------------------------------------------------------
  // register word views
  // --------------------------------------------------------------------------

  // nco view
  // bit 0 start strobe on write, bit 1 done flag on read
  typedef struct packed {
    logic [ctrlport_pkg::data_w-3:0] rsvd;
    logic                            done;
    logic                            start;
  } nco_word_t;

  // gearbox view
  // bit 0 adc gearbox reset, bit 1 dac gearbox reset, both write-only strobes
  typedef struct packed {
    logic [ctrlport_pkg::data_w-3:0] rsvd;
    logic                            dac_rst;
    logic                            adc_rst;
  } gearbox_word_t;

  // one data word, read through the view picked by the address
  typedef union packed {
    logic [ctrlport_pkg::data_w-1:0] raw;
    nco_word_t                       nco;
    gearbox_word_t                   gearbox;
  } reg_word_u;

endpackage

// ==== hw/ctrlport_if.sv ====
// control-port bundle between timer and register endpoint, with source and sink modports
`timescale 1ns/100ps

interface ctrlport_if;

  // request side, driven by the source
  // one-cycle pulse on req_wr or req_rd
  logic                              req_wr;
  logic                              req_rd;
  logic [ctrlport_pkg::addr_w-1:0]   req_addr;
  logic [ctrlport_pkg::data_w-1:0]   req_data;
  logic                              req_has_time;
  logic [ctrlport_pkg::time_w-1:0]   req_time;

  // response side, driven by the sink
  // resp_ack pulses once per request and ends it
  logic                              resp_ack;
  ctrlport_pkg::status_t             resp_status;
  logic [ctrlport_pkg::data_w-1:0]   resp_data;

  // requester
  modport source (
    output req_wr, req_rd, req_addr, req_data, req_has_time, req_time,
    input  resp_ack, resp_status, resp_data
  );

  // responder
  modport sink (
    input  req_wr, req_rd, req_addr, req_data, req_has_time, req_time,
    output resp_ack, resp_status, resp_data
  );

endinterface

// ==== hw/ctrlport_timer.sv ====
// command timer: holds one timed control-port request until radio time, then forwards it
`timescale 1ns/100ps

module ctrlport_timer (
  input  logic                            clk,
  input  logic                            rst,
  ctrlport_if.sink                        up,
  ctrlport_if.source                      down,
  input  logic [ctrlport_pkg::time_w-1:0] time_now
);

  // --------------------------------------------------------------------------
  // holding register
  // --------------------------------------------------------------------------

  // control state
  logic pending;
  logic fwd_wr;
  logic fwd_rd;

  // captured request payload
  logic                            hold_wr;
  logic                            hold_rd;
  logic [ctrlport_pkg::addr_w-1:0] hold_addr;
  logic [ctrlport_pkg::data_w-1:0] hold_data;
  logic [ctrlport_pkg::time_w-1:0] hold_time;

  logic up_req;
  logic run_now;
  logic time_hit;

  assign up_req = up.req_wr | up.req_rd;

  // untimed, or stamp already reached
  assign run_now = !up.req_has_time || (up.req_time <= time_now);

  // held stamp reached at this edge
  assign time_hit = pending && (time_now >= hold_time);

  // payload, captured with every new request
  always_ff @(posedge clk) begin
    if (up_req) begin
      hold_wr   <= up.req_wr;
      hold_rd   <= up.req_rd;
      hold_addr <= up.req_addr;
      hold_data <= up.req_data;
      hold_time <= up.req_time;
    end
  end

  // pending flag and the forwarded strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      fwd_wr  <= 1'b0;
      fwd_rd  <= 1'b0;
    end else begin
      // strobes last one cycle
      fwd_wr <= 1'b0;
      fwd_rd <= 1'b0;
      if (up_req) begin
        if (run_now) begin
          // late or untimed, goes out next cycle
          fwd_wr <= up.req_wr;
          fwd_rd <= up.req_rd;
        end else begin
          pending <= 1'b1;
        end
      end else if (time_hit) begin
        // release the held command
        fwd_wr  <= hold_wr;
        fwd_rd  <= hold_rd;
        pending <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // endpoint side
  // --------------------------------------------------------------------------

  assign down.req_wr       = fwd_wr;
  assign down.req_rd       = fwd_rd;
  assign down.req_addr     = hold_addr;
  assign down.req_data     = hold_data;
  // already executed at its time
  assign down.req_has_time = 1'b0;
  assign down.req_time     = hold_time;

  // response straight back to the requester
  assign up.resp_ack    = down.resp_ack;
  assign up.resp_status = down.resp_status;
  assign up.resp_data   = down.resp_data;

  // one outstanding request per port, so nothing new while one is held
  a_no_req_while_pending : assert property (
    @(posedge clk) disable iff (rst) pending |-> !up_req
  );

endmodule

// ==== hw/rfdc_db_regs.sv ====
// per-board register endpoint: decodes nco and gearbox register accesses into reset strobes
`timescale 1ns/100ps

module rfdc_db_regs (
  input  logic     clk,
  input  logic     rst,
  ctrlport_if.sink ctl,
  input  logic     nco_done,
  output logic     nco_start,
  output logic     adc_rst,
  output logic     dac_rst
);

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------

  logic nco_sel;
  logic gb_sel;
  logic hit;
  logic acc;

  // same write word, two views
  rfdc_regmap_pkg::reg_word_u wr_word;
  // read-back word
  rfdc_regmap_pkg::reg_word_u rd_word;

  logic                            ack_q;
  logic [ctrlport_pkg::data_w-1:0] data_q;

  assign nco_sel = ctl.req_addr == rfdc_regmap_pkg::nco_reset_reg_addr;
  assign gb_sel  = ctl.req_addr == rfdc_regmap_pkg::gearbox_reset_reg_addr;
  assign hit     = nco_sel | gb_sel;
  assign acc     = ctl.req_wr | ctl.req_rd;

  assign wr_word = ctl.req_data;

  // read data
  // gearbox bits are write-only and read back as zero
  always_comb begin
    rd_word = '0;
    if (nco_sel) begin
      rd_word.nco.done = nco_done;
    end
  end

  // --------------------------------------------------------------------------
  // strobes and ack
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q     <= 1'b0;
      nco_start <= 1'b0;
      adc_rst   <= 1'b0;
      dac_rst   <= 1'b0;
    end else begin
      // unmapped addresses are dropped without ack
      ack_q     <= acc && hit;
      // nco view on the nco register
      nco_start <= ctl.req_wr && nco_sel && wr_word.nco.start;
      // gearbox view on the gearbox register
      adc_rst   <= ctl.req_wr && gb_sel && wr_word.gearbox.adc_rst;
      dac_rst   <= ctl.req_wr && gb_sel && wr_word.gearbox.dac_rst;
    end
  end

  // response word, zero on writes
  always_ff @(posedge clk) begin
    if (acc) begin
      data_q <= ctl.req_rd ? rd_word.raw : '0;
    end
  end

  assign ctl.resp_ack    = ack_q;
  assign ctl.resp_status = ctrlport_pkg::sts_okay;
  assign ctl.resp_data   = data_q;

  // the timer forwards one request at a time, so acks never come back to back
  a_ack_single : assert property (
    @(posedge clk) disable iff (rst) ack_q |=> !ack_q
  );

endmodule

// ==== hw/rfdc_reset_merge.sv ====
// merges both boards' reset strobes into single converter pulses and syncs the nco done flag
`timescale 1ns/100ps

module rfdc_reset_merge (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] nco_start,
  input  logic [1:0] adc_rst,
  input  logic [1:0] dac_rst,
  input  logic       nco_reset_done,
  output logic       nco_done,
  output logic       start_nco_reset,
  output logic       adc_reset_pulse,
  output logic       dac_reset_pulse
);

  // --------------------------------------------------------------------------
  // reset pulses
  // --------------------------------------------------------------------------

  // one converter reset per kind, shared by both boards
  // strobes are one cycle wide, so the OR stays one cycle wide too
  // same-cycle requests from both boards collapse into one pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      start_nco_reset <= 1'b0;
      adc_reset_pulse <= 1'b0;
      dac_reset_pulse <= 1'b0;
    end else begin
      start_nco_reset <= |nco_start;
      adc_reset_pulse <= |adc_rst;
      dac_reset_pulse <= |dac_rst;
    end
  end

  // --------------------------------------------------------------------------
  // done flag synchronizer
  // --------------------------------------------------------------------------

  // flag comes from the converter, asynchronous to clk
  logic [rfdc_regmap_pkg::sync_stages-1:0] done_sync;

  // shift in at bit 0
  always_ff @(posedge clk) begin
    if (rst) begin
      done_sync <= '0;
    end else begin
      done_sync <= {done_sync[rfdc_regmap_pkg::sync_stages-2:0], nco_reset_done};
    end
  end

  // last stage, shared with both endpoints for read-back
  assign nco_done = done_sync[rfdc_regmap_pkg::sync_stages-1];

  // no converter pulse straight out of reset
  a_quiet_after_reset : assert property (
    @(posedge clk) $past(rst) |-> !(start_nco_reset || adc_reset_pulse || dac_reset_pulse)
  );

endmodule

// ==== hw/rfdc_timing_top.sv ====
// rfdc timed reset-control top: two board paths of timer and endpoint feeding one merge stage
`timescale 1ns/100ps

module rfdc_timing_top (
  input  logic                            clk,
  input  logic                            rst,
  // board 0 control port
  input  logic                            db0_req_wr,
  input  logic                            db0_req_rd,
  input  logic [ctrlport_pkg::addr_w-1:0] db0_req_addr,
  input  logic [ctrlport_pkg::data_w-1:0] db0_req_data,
  input  logic                            db0_req_has_time,
  input  logic [ctrlport_pkg::time_w-1:0] db0_req_time,
  output logic                            db0_resp_ack,
  output ctrlport_pkg::status_t           db0_resp_status,
  output logic [ctrlport_pkg::data_w-1:0] db0_resp_data,
  // board 1 control port
  input  logic                            db1_req_wr,
  input  logic                            db1_req_rd,
  input  logic [ctrlport_pkg::addr_w-1:0] db1_req_addr,
  input  logic [ctrlport_pkg::data_w-1:0] db1_req_data,
  input  logic                            db1_req_has_time,
  input  logic [ctrlport_pkg::time_w-1:0] db1_req_time,
  output logic                            db1_resp_ack,
  output ctrlport_pkg::status_t           db1_resp_status,
  output logic [ctrlport_pkg::data_w-1:0] db1_resp_data,
  // radio time and converter
  input  logic [ctrlport_pkg::time_w-1:0] time_now,
  input  logic                            nco_reset_done,
  output logic                            start_nco_reset,
  output logic                            adc_reset_pulse,
  output logic                            dac_reset_pulse
);

  // port side and endpoint side of each board's timer
  ctrlport_if db0_up ();
  ctrlport_if db0_down ();
  ctrlport_if db1_up ();
  ctrlport_if db1_down ();

  // per-board strobes, bit index is the board
  logic [1:0] nco_start;
  logic [1:0] adc_rst;
  logic [1:0] dac_rst;
  logic       nco_done;

  // --------------------------------------------------------------------------
  // board 0
  // --------------------------------------------------------------------------

  assign db0_up.req_wr       = db0_req_wr;
  assign db0_up.req_rd       = db0_req_rd;
  assign db0_up.req_addr     = db0_req_addr;
  assign db0_up.req_data     = db0_req_data;
  assign db0_up.req_has_time = db0_req_has_time;
  assign db0_up.req_time     = db0_req_time;
  assign db0_resp_ack        = db0_up.resp_ack;
  assign db0_resp_status     = db0_up.resp_status;
  assign db0_resp_data       = db0_up.resp_data;

  ctrlport_timer timer0 (.clk, .rst, .up(db0_up), .down(db0_down), .time_now);

  rfdc_db_regs regs0 (
    .clk, .rst, .ctl(db0_down), .nco_done,
    .nco_start(nco_start[0]), .adc_rst(adc_rst[0]), .dac_rst(dac_rst[0])
  );

  // --------------------------------------------------------------------------
  // board 1
  // --------------------------------------------------------------------------

  assign db1_up.req_wr       = db1_req_wr;
  assign db1_up.req_rd       = db1_req_rd;
  assign db1_up.req_addr     = db1_req_addr;
  assign db1_up.req_data     = db1_req_data;
  assign db1_up.req_has_time = db1_req_has_time;
  assign db1_up.req_time     = db1_req_time;
  assign db1_resp_ack        = db1_up.resp_ack;
  assign db1_resp_status     = db1_up.resp_status;
  assign db1_resp_data       = db1_up.resp_data;

  ctrlport_timer timer1 (.clk, .rst, .up(db1_up), .down(db1_down), .time_now);

  rfdc_db_regs regs1 (
    .clk, .rst, .ctl(db1_down), .nco_done,
    .nco_start(nco_start[1]), .adc_rst(adc_rst[1]), .dac_rst(dac_rst[1])
  );

  // shared converter resets and done flag
  rfdc_reset_merge merge (
    .clk, .rst, .nco_start, .adc_rst, .dac_rst, .nco_reset_done, .nco_done,
    .start_nco_reset, .adc_reset_pulse, .dac_reset_pulse
  );

endmodule

// ==== tb/rfdc_timing_tb_checks.svh ====
// testbench helpers for the rfdc reset block: lcg, reference model and typed compares
`ifndef RFDC_TIMING_TB_CHECKS_SVH
`define RFDC_TIMING_TB_CHECKS_SVH

// lcg step, numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// expected result of one access
// returns {nco, adc, dac pulses, read word}
function automatic logic [34:0] ref_access(input logic wr, input logic [19:0] addr,
                                           input logic [31:0] data, input logic done);
  logic [2:0]  pulses;
  logic [31:0] rdata;
  pulses = 3'b000;
  rdata  = '0;
  if (wr) begin
    // start bit 0 on the nco register, adc bit 0 / dac bit 1 on the gearbox register
    pulses[2] = (addr == 20'h0) && data[0];
    pulses[1] = (addr == 20'h4) && data[0];
    pulses[0] = (addr == 20'h4) && data[1];
  end else if (addr == 20'h0) begin
    // done flag in bit 1
    rdata[1] = done;
  end
  return {pulses, rdata};
endfunction

task automatic report_mismatch(input string msg);
  $display("mismatch at %0t ns: %s", $time, msg);
  $display("TB FAILED");
  $fatal(1, "check failed");
endtask

task automatic compare_status(input ctrlport_pkg::status_t got, input ctrlport_pkg::status_t exp);
  if (got !== exp)
    report_mismatch($sformatf("resp_status got %b expected %b", got, exp));
endtask

task automatic compare_word(input string what, input logic [ctrlport_pkg::data_w-1:0] got,
                            input logic [ctrlport_pkg::data_w-1:0] exp);
  if (got !== exp)
    report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
endtask

// pulse set ordered {start_nco_reset, adc_reset_pulse, dac_reset_pulse}
task automatic compare_pulses(input logic [2:0] got, input logic [2:0] exp);
  if (got !== exp)
    report_mismatch($sformatf("pulse set got %b expected %b", got, exp));
endtask

task automatic compare_count(input string what, input int got, input int exp);
  if (got != exp)
    report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
endtask

`endif

// ==== tb/rfdc_timing_tb.sv ====
// testbench for rfdc_timing_top, run as top module rfdc_timing_tb with the sources.f file list
`timescale 1ns/100ps

module rfdc_timing_tb;

  logic                            clk;
  logic                            rst;
  logic                            req_wr [2];
  logic                            req_rd [2];
  logic [ctrlport_pkg::addr_w-1:0] req_addr [2];
  logic [ctrlport_pkg::data_w-1:0] req_data [2];
  logic                            req_has_time [2];
  logic [ctrlport_pkg::time_w-1:0] req_time [2];
  logic                            resp_ack [2];
  ctrlport_pkg::status_t           resp_status [2];
  logic [ctrlport_pkg::data_w-1:0] resp_data [2];
  logic [ctrlport_pkg::time_w-1:0] time_now;
  logic                            conv_done;
  logic                            start_nco_reset;
  logic                            adc_reset_pulse;
  logic                            dac_reset_pulse;

  // converter model and pulse bookkeeping
  logic [31:0] model_seed = 32'h229b935a;
  logic [31:0] stim_seed  = 32'h229b935a;
  int          conv_cnt;
  logic [2:0]  prev_pulses;
  int          cnt_nco, cnt_adc, cnt_dac;
  int          exp_nco, exp_adc, exp_dac;

  `include "rfdc_timing_tb_checks.svh"

  rfdc_timing_top UUT (
    .clk, .rst,
    .db0_req_wr(req_wr[0]), .db0_req_rd(req_rd[0]), .db0_req_addr(req_addr[0]),
    .db0_req_data(req_data[0]), .db0_req_has_time(req_has_time[0]),
    .db0_req_time(req_time[0]), .db0_resp_ack(resp_ack[0]),
    .db0_resp_status(resp_status[0]), .db0_resp_data(resp_data[0]),
    .db1_req_wr(req_wr[1]), .db1_req_rd(req_rd[1]), .db1_req_addr(req_addr[1]),
    .db1_req_data(req_data[1]), .db1_req_has_time(req_has_time[1]),
    .db1_req_time(req_time[1]), .db1_resp_ack(resp_ack[1]),
    .db1_resp_status(resp_status[1]), .db1_resp_data(resp_data[1]),
    .time_now, .nco_reset_done(conv_done),
    .start_nco_reset, .adc_reset_pulse, .dac_reset_pulse
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // radio time, one tick per cycle
  always @(posedge clk) time_now <= time_now + 1;

  // ---------------------------------------------------------------------------
  // converter model
  // ---------------------------------------------------------------------------

  // done rises 3 to 10 cycles after a start, cleared by the next start
  always @(posedge clk) begin
    if (rst) begin
      conv_done <= 1'b0;
      conv_cnt  <= 0;
    end else if (start_nco_reset) begin
      conv_done  <= 1'b0;
      model_seed <= lcg_next(model_seed);
      conv_cnt   <= 3 + int'(lcg_next(model_seed) % 8);
    end else if (conv_cnt != 0) begin
      conv_cnt <= conv_cnt - 1;
      if (conv_cnt == 1)
        conv_done <= 1'b1;
    end
  end

  // comparing process, counts pulses and checks they are one cycle wide
  always @(posedge clk) begin
    if (rst) begin
      prev_pulses <= 3'b000;
    end else begin
      if (|({start_nco_reset, adc_reset_pulse, dac_reset_pulse} & prev_pulses))
        report_mismatch("reset pulse wider than one cycle");
      cnt_nco     <= cnt_nco + start_nco_reset;
      cnt_adc     <= cnt_adc + adc_reset_pulse;
      cnt_dac     <= cnt_dac + dac_reset_pulse;
      prev_pulses <= {start_nco_reset, adc_reset_pulse, dac_reset_pulse};
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------------

  // one-cycle request, sampled by the dut at the edge this task returns on
  task automatic issue(input int p, input logic wr, input logic [19:0] addr,
                       input logic [31:0] data, input logic has_t, input logic [63:0] stamp);
    @(posedge clk);
    req_wr[p]       <= wr;
    req_rd[p]       <= !wr;
    req_addr[p]     <= addr;
    req_data[p]     <= data;
    req_has_time[p] <= has_t;
    req_time[p]     <= stamp;
    @(posedge clk);
    req_wr[p] <= 1'b0;
    req_rd[p] <= 1'b0;
  endtask

  task automatic wait_ack(input int p, input int limit, input bit must,
                          output int cycles, output bit found);
    cycles = 0;
    found  = 0;
    while (!found && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
      found = resp_ack[p];
    end
    if (!found && must) begin
      $display("timeout: no ack on port %0d within %0d cycles", p, limit);
      $display("TB FAILED");
      $fatal(1, "ack wait expired");
    end
  endtask

  // full access, checked against the reference
  task automatic do_access(input int p, input logic wr, input logic [19:0] addr,
                           input logic [31:0] data, input logic has_t,
                           input logic [63:0] stamp, input logic done_exp, input bit chk_lat);
    logic [34:0] exp;
    int          cyc;
    bit          found;
    exp = ref_access(wr, addr, data, done_exp);
    issue(p, wr, addr, data, has_t, stamp);
    wait_ack(p, 80, 1, cyc, found);
    // ack shows one edge after the request edge and is sampled high at N+2
    if (chk_lat)
      compare_count("ack latency", cyc + 1, 2);
    compare_status(resp_status[p], ctrlport_pkg::sts_okay);
    if (!wr)
      compare_word("read data", resp_data[p], exp[31:0]);
    exp_nco += exp[34];
    exp_adc += exp[33];
    exp_dac += exp[32];
  endtask

  // pulse set in the cycle after ack, then quiet
  task automatic check_pulse_window(input logic [2:0] exp);
    @(posedge clk);
    #1;
    compare_pulses({start_nco_reset, adc_reset_pulse, dac_reset_pulse}, exp);
    @(posedge clk);
    #1;
    compare_pulses({start_nco_reset, adc_reset_pulse, dac_reset_pulse}, 3'b000);
  endtask

  task automatic wait_done_settle();
    int n;
    n = 0;
    // let a fresh start pulse reach the converter model first
    repeat (2) @(posedge clk);
    #1;
    while (!conv_done && n < 30) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!conv_done) begin
      $display("timeout: converter done flag never rose");
      $display("TB FAILED");
      $fatal(1, "done wait expired");
    end
    repeat (rfdc_regmap_pkg::sync_stages + 1) @(posedge clk);
    #1;
  endtask

  task automatic check_counts();
    repeat (3) @(posedge clk);
    #1;
    compare_count("nco pulses", cnt_nco, exp_nco);
    compare_count("adc pulses", cnt_adc, exp_adc);
    compare_count("dac pulses", cnt_dac, exp_dac);
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------

  initial begin
    logic [31:0] r;
    logic [63:0] stamp;
    logic [19:0] addr;
    int          cyc;
    bit          found;
    rst = 1'b1;
    time_now = '0;
    conv_done = 1'b0;
    cnt_nco = 0;
    cnt_adc = 0;
    cnt_dac = 0;
    exp_nco = 0;
    exp_adc = 0;
    exp_dac = 0;
    for (int p = 0; p < 2; p++) begin
      req_wr[p] = 1'b0;
      req_rd[p] = 1'b0;
      req_addr[p] = '0;
      req_data[p] = '0;
      req_has_time[p] = 1'b0;
      req_time[p] = '0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    // untimed gearbox write, random adc and dac bits
    stim_seed = lcg_next(stim_seed);
    r = {30'b0, stim_seed[17:16]};
    do_access(0, 1, 20'h4, r, 0, 0, conv_done, 1);
    check_pulse_window({1'b0, r[0], r[1]});

    // nco start, done read back before and after the converter finishes
    do_access(1, 1, 20'h0, 32'h1, 0, 0, conv_done, 1);
    do_access(1, 0, 20'h0, 32'h0, 0, 0, 1'b0, 1);
    wait_done_settle();
    do_access(1, 0, 20'h0, 32'h0, 0, 0, 1'b1, 1);
    check_counts();

    // timed write 40 cycles ahead, nothing before the stamp
    stamp = time_now + 40;
    issue(0, 1, 20'h4, 32'h1, 1, stamp);
    cyc = 0;
    found = 0;
    while (!found && cyc < 80) begin
      @(posedge clk);
      #1;
      cyc++;
      if ((resp_ack[0] || adc_reset_pulse) && time_now < stamp)
        report_mismatch("timed write executed before its stamp");
      found = resp_ack[0];
    end
    if (!found) begin
      $display("timeout: timed write was never acknowledged");
      $display("TB FAILED");
      $fatal(1, "timed ack wait expired");
    end
    exp_adc += 1;
    check_pulse_window(3'b010);
    // stamp in the past runs like an untimed write
    do_access(0, 1, 20'h4, 32'h2, 1, time_now - 5, conv_done, 1);
    check_counts();

    // same gearbox bit from both boards in one cycle gives one pulse
    @(posedge clk);
    for (int p = 0; p < 2; p++) begin
      req_wr[p] <= 1'b1;
      req_addr[p] <= 20'h4;
      req_data[p] <= 32'h1;
      req_has_time[p] <= 1'b0;
    end
    @(posedge clk);
    req_wr[0] <= 1'b0;
    req_wr[1] <= 1'b0;
    wait_ack(0, 20, 1, cyc, found);
    if (!resp_ack[1])
      report_mismatch("board 1 ack missing in simultaneous write");
    exp_adc += 1;
    check_pulse_window(3'b010);
    check_counts();

    // unmapped addresses are never acked
    issue(0, 1, 20'h10, 32'h3, 0, 0);
    wait_ack(0, 20, 0, cyc, found);
    if (found)
      report_mismatch("ack for unmapped write");
    issue(1, 0, 20'h8, 32'h0, 0, 0);
    wait_ack(1, 20, 0, cyc, found);
    if (found)
      report_mismatch("ack for unmapped read");
    do_access(0, 0, 20'h4, 32'h0, 0, 0, conv_done, 1);
    do_access(1, 1, 20'h4, 32'h2, 0, 0, conv_done, 1);
    check_counts();

    // random traffic over both ports
    for (int i = 0; i < 50; i++) begin
      stim_seed = lcg_next(stim_seed);
      r = stim_seed;
      addr = r[12] ? 20'h0 : 20'h4;
      do_access(r[10], r[11], addr, {30'b0, r[17:16]}, r[13], time_now + r[15:14],
                conv_done, 0);
      if (r[11] && addr == 20'h0 && r[16])
        wait_done_settle();
    end
    check_counts();

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+tb
hw/ctrlport_pkg.sv
hw/rfdc_regmap_pkg.sv
hw/ctrlport_if.sv
hw/ctrlport_timer.sv
hw/rfdc_db_regs.sv
hw/rfdc_reset_merge.sv
hw/rfdc_timing_top.sv
tb/rfdc_timing_tb.sv
